//--- verilog/stq_cfg.svh
`ifndef STQ_CFG_SVH
`define STQ_CFG_SVH

// Store queue sizing
`define STQ_NUM_ENTRIES 8
`define ROB_ID_W        5

// Memory word and line geometry
`define MEM_ADDR_W      16
`define MEM_DATA_W      32
`define MEM_LINE_LSB    4    // Bits below this are offset within the line

// Registered stages mm1 to mm5
`define MEM_PIPE_DEPTH  5

`endif

//--- verilog/mem_pkg.sv
`include "stq_cfg.svh"

package mem_pkg;

    typedef logic [`ROB_ID_W-1:0]                t_rob_id;
    typedef logic [$clog2(`STQ_NUM_ENTRIES)-1:0] t_stq_id;

    typedef enum logic [1:0] {
        OP_ALU   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } t_opcode;

    typedef struct packed {
        t_opcode                opcode;
        t_rob_id                robid;
        t_stq_id                stqid;
        logic [`MEM_ADDR_W-1:0] vaddr;
        logic [`MEM_DATA_W-1:0] data;
    } t_iss_pkt;

    typedef struct packed {
        logic    valid;
        t_rob_id robid;  // Everything this age and younger goes
    } t_nuke_pkt;

    typedef struct packed {
        t_stq_id                stqid;
        t_rob_id                robid;
        logic [`MEM_ADDR_W-1:0] vaddr;
        logic [`MEM_DATA_W-1:0] data;
    } t_mempipe_arb;

    typedef enum logic [1:0] {
        ACT_NONE     = 2'd0,
        ACT_COMPLETE = 2'd1,
        ACT_REPLAY   = 2'd2
    } t_mempipe_action;

    typedef struct packed {
        t_rob_id                robid;
        logic [`MEM_ADDR_W-1:0] vaddr;
        logic [`MEM_DATA_W-1:0] data;
    } t_stq_static;

    typedef struct packed {
        t_rob_id                robid;
        logic [`MEM_ADDR_W-1:0] vaddr;
        logic [`MEM_DATA_W-1:0] data;
    } t_commit_pkt;

    // Distances from the oldest id wrap modulo the ROB size
    function automatic logic rob_is_younger_eq(t_rob_id robid, t_rob_id ref_robid,
                                               t_rob_id oldest);
        t_rob_id dist_robid;
        t_rob_id dist_ref;
        dist_robid = robid - oldest;
        dist_ref   = ref_robid - oldest;
        return dist_robid >= dist_ref;
    endfunction

endpackage

//--- verilog/find_first_arb.sv
`timescale 1ns/1ns
`include "stq_cfg.svh"

// Lowest index wins. Clock and reset go unused by this policy
module find_first_arb (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [`STQ_NUM_ENTRIES-1:0]  req_valids,
    input  mem_pkg::t_mempipe_arb        req_pkts [`STQ_NUM_ENTRIES-1:0],
    output logic [`STQ_NUM_ENTRIES-1:0]  gnts,
    output logic                         out_valid,
    output mem_pkg::t_mempipe_arb        out_pkt,
    input  logic                         out_gnt
);

logic [`STQ_NUM_ENTRIES-1:0] sel;

// Isolate lowest set bit
assign sel       = req_valids & (~req_valids + `STQ_NUM_ENTRIES'(1));
assign out_valid = |req_valids;
assign gnts      = out_gnt ? sel : '0;

// ------------------------------------------------------------
// Winner packet mux
// ------------------------------------------------------------

always_comb begin
    out_pkt = '0;
    for (int i = 0; i < `STQ_NUM_ENTRIES; i++) begin
        if (sel[i]) begin
            out_pkt = req_pkts[i];
        end
    end
end

endmodule

//--- verilog/stq_entry.sv
`timescale 1ns/1ns

module stq_entry (
    input  logic                      clk,
    input  logic                      arst_n,
    input  mem_pkg::t_stq_id          id,
    input  mem_pkg::t_nuke_pkt        nuke,
    input  mem_pkg::t_rob_id          oldest_robid,
    input  logic                      alloc,
    input  mem_pkg::t_stq_static      alloc_static,
    output logic                      valid,
    output logic                      req,
    output mem_pkg::t_mempipe_arb     req_pkt,
    input  logic                      gnt,
    input  logic                      pipe_valid_mm5,
    input  mem_pkg::t_mempipe_arb     pipe_pkt_mm5,
    input  mem_pkg::t_mempipe_action  pipe_action_mm5
);

logic                 inflight;   // Sent to pipe, result not back yet
logic                 waiting;
logic                 hit_mm5;
logic                 nuke_hit;
logic                 nuke_alloc;
mem_pkg::t_stq_static st;

// ------------------------------------------------------------
// Status decode
// ------------------------------------------------------------

assign waiting = valid & ~inflight;

// Only our own in-flight op may act on us
assign hit_mm5 = pipe_valid_mm5 && inflight && (pipe_pkt_mm5.stqid == id);

assign nuke_hit = nuke.valid &&
                  mem_pkg::rob_is_younger_eq(st.robid, nuke.robid, oldest_robid);

// Store arriving in the nuke cycle may itself be flushed
assign nuke_alloc = nuke.valid &&
                    mem_pkg::rob_is_younger_eq(alloc_static.robid, nuke.robid, oldest_robid);

// ------------------------------------------------------------
// Flags
// ------------------------------------------------------------

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        valid    <= 1'b0;
        inflight <= 1'b0;
    end else if (alloc) begin
        valid    <= ~nuke_alloc;
        inflight <= 1'b0;
    end else if (valid && nuke_hit) begin
        valid    <= 1'b0;
        inflight <= 1'b0;
    end else if (hit_mm5) begin
        case (pipe_action_mm5)
            mem_pkg::ACT_COMPLETE: begin
                valid    <= 1'b0;
                inflight <= 1'b0;
            end
            mem_pkg::ACT_REPLAY: begin
                inflight <= 1'b0;  // Back to waiting, asks again next cycle
            end
            default: begin
                inflight <= inflight;
            end
        endcase
    end else if (gnt) begin
        inflight <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (alloc) begin
        st <= alloc_static;
    end
end

// ------------------------------------------------------------
// Pipe request
// ------------------------------------------------------------

assign req = waiting;

always_comb begin
    req_pkt.stqid = id;
    req_pkt.robid = st.robid;
    req_pkt.vaddr = st.vaddr;
    req_pkt.data  = st.data;
end

endmodule

//--- verilog/storeq.sv
`timescale 1ns/1ns
`include "stq_cfg.svh"

module storeq (
    input  logic                         clk,
    input  logic                         arst_n,
    input  mem_pkg::t_nuke_pkt           nuke,
    input  mem_pkg::t_rob_id             oldest_robid,

    input  logic                         iss_valid,
    input  mem_pkg::t_iss_pkt            iss_pkt,

    output logic                         pipe_req,
    output mem_pkg::t_mempipe_arb        pipe_req_pkt,
    input  logic                         pipe_gnt,

    input  logic                         pipe_valid_mm5,
    input  mem_pkg::t_mempipe_arb        pipe_pkt_mm5,
    input  mem_pkg::t_mempipe_action     pipe_action_mm5,

    output logic [`STQ_NUM_ENTRIES-1:0]  stq_valids
);

logic                        q_alloc;
logic [`STQ_NUM_ENTRIES-1:0] e_alloc;
mem_pkg::t_stq_static        alloc_static;

logic [`STQ_NUM_ENTRIES-1:0] e_req;
mem_pkg::t_mempipe_arb       e_req_pkt [`STQ_NUM_ENTRIES-1:0];
logic [`STQ_NUM_ENTRIES-1:0] e_gnt;

// ------------------------------------------------------------
// Allocation
// ------------------------------------------------------------

assign q_alloc = iss_valid && (iss_pkt.opcode == mem_pkg::OP_STORE);
assign e_alloc = q_alloc ? (`STQ_NUM_ENTRIES'(1) << iss_pkt.stqid) : '0;

always_comb begin
    alloc_static.robid = iss_pkt.robid;
    alloc_static.vaddr = iss_pkt.vaddr;
    alloc_static.data  = iss_pkt.data;
end

// ------------------------------------------------------------
// Pipe arbitration
// ------------------------------------------------------------

find_first_arb pipe_arb (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valids (e_req),
    .req_pkts   (e_req_pkt),
    .gnts       (e_gnt),
    .out_valid  (pipe_req),
    .out_pkt    (pipe_req_pkt),
    .out_gnt    (pipe_gnt)
);

// ------------------------------------------------------------
// Entries
// ------------------------------------------------------------

for (genvar e = 0; e < `STQ_NUM_ENTRIES; e++) begin : g_entry
    stq_entry u_entry (
        .clk             (clk),
        .arst_n          (arst_n),
        .id              (mem_pkg::t_stq_id'(e)),
        .nuke            (nuke),
        .oldest_robid    (oldest_robid),
        .alloc           (e_alloc[e]),
        .alloc_static    (alloc_static),
        .valid           (stq_valids[e]),
        .req             (e_req[e]),
        .req_pkt         (e_req_pkt[e]),
        .gnt             (e_gnt[e]),
        .pipe_valid_mm5  (pipe_valid_mm5),
        .pipe_pkt_mm5    (pipe_pkt_mm5),
        .pipe_action_mm5 (pipe_action_mm5)
    );
end

endmodule

//--- verilog/mem_pipe.sv
`timescale 1ns/1ns
`include "stq_cfg.svh"

module mem_pipe (
    input  logic                      clk,
    input  logic                      arst_n,
    input  mem_pkg::t_nuke_pkt        nuke,
    input  mem_pkg::t_rob_id          oldest_robid,
    input  logic                      pipe_stall,

    input  logic                      pipe_req,
    input  mem_pkg::t_mempipe_arb     pipe_req_pkt,
    output logic                      pipe_gnt,

    output logic                      pipe_valid_mm5,
    output mem_pkg::t_mempipe_arb     pipe_pkt_mm5,
    output mem_pkg::t_mempipe_action  pipe_action_mm5,

    output logic                      commit_valid,
    output mem_pkg::t_commit_pkt      commit_pkt
);

localparam int D = `MEM_PIPE_DEPTH;

typedef struct packed {
    logic                  replay;  // Decided once at mm0
    mem_pkg::t_mempipe_arb req;
} t_stage;

logic [D:1]  stg_v;
t_stage      stg [D:1];
logic [D:1]  kill;
logic        kill_mm0;
logic        conflict_mm0;
logic        accept_mm0;

function automatic logic [`MEM_ADDR_W-1:`MEM_LINE_LSB] line_of(
    logic [`MEM_ADDR_W-1:0] vaddr);
    return vaddr[`MEM_ADDR_W-1:`MEM_LINE_LSB];
endfunction

// ------------------------------------------------------------
// mm0 entry
// ------------------------------------------------------------

assign pipe_gnt = ~pipe_stall;

assign kill_mm0 = nuke.valid &&
                  mem_pkg::rob_is_younger_eq(pipe_req_pkt.robid, nuke.robid, oldest_robid);
assign accept_mm0 = pipe_req && pipe_gnt && !kill_mm0;

always_comb begin
    conflict_mm0 = 1'b0;
    for (int s = 1; s < D; s++) begin  // mm1..mm4
        if (stg_v[s] && line_of(stg[s].req.vaddr) == line_of(pipe_req_pkt.vaddr)) begin
            conflict_mm0 = 1'b1;
        end
    end
end

// ------------------------------------------------------------
// Stages mm1 to mm5
// ------------------------------------------------------------

always_comb begin
    for (int s = 1; s <= D; s++) begin
        kill[s] = nuke.valid &&
                  mem_pkg::rob_is_younger_eq(stg[s].req.robid, nuke.robid, oldest_robid);
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        stg_v <= '0;
    end else begin
        stg_v[1] <= accept_mm0;
        for (int s = 2; s <= D; s++) begin
            stg_v[s] <= stg_v[s-1] && !kill[s-1];
        end
    end
end

always_ff @(posedge clk) begin
    stg[1].replay <= conflict_mm0;
    stg[1].req    <= pipe_req_pkt;
    for (int s = 2; s <= D; s++) begin
        stg[s] <= stg[s-1];
    end
end

// ------------------------------------------------------------
// mm5 result and commit
// ------------------------------------------------------------

assign pipe_valid_mm5 = stg_v[D] && !kill[D];  // Nuked op never reports
assign pipe_pkt_mm5   = stg[D].req;

always_comb begin
    pipe_action_mm5 = mem_pkg::ACT_NONE;
    if (pipe_valid_mm5) begin
        pipe_action_mm5 = stg[D].replay ? mem_pkg::ACT_REPLAY : mem_pkg::ACT_COMPLETE;
    end
end

assign commit_valid     = (pipe_action_mm5 == mem_pkg::ACT_COMPLETE);
assign commit_pkt.robid = stg[D].req.robid;
assign commit_pkt.vaddr = stg[D].req.vaddr;
assign commit_pkt.data  = stg[D].req.data;

endmodule

//--- verilog/mem_subsys.sv
`timescale 1ns/1ns
`include "stq_cfg.svh"

module mem_subsys (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         iss_valid,
    input  mem_pkg::t_iss_pkt            iss_pkt,
    input  mem_pkg::t_nuke_pkt           nuke,
    input  mem_pkg::t_rob_id             oldest_robid,
    input  logic                         pipe_stall,
    output logic                         commit_valid,
    output mem_pkg::t_commit_pkt         commit_pkt,
    output logic [`STQ_NUM_ENTRIES-1:0]  stq_valids
);

// Queue to pipe request path
logic                     pipe_req;
mem_pkg::t_mempipe_arb    pipe_req_pkt;
logic                     pipe_gnt;

// Pipe result back to every entry
logic                     pipe_valid_mm5;
mem_pkg::t_mempipe_arb    pipe_pkt_mm5;
mem_pkg::t_mempipe_action pipe_action_mm5;

storeq u_storeq (
    .clk             (clk),
    .arst_n          (arst_n),
    .nuke            (nuke),
    .oldest_robid    (oldest_robid),
    .iss_valid       (iss_valid),
    .iss_pkt         (iss_pkt),
    .pipe_req        (pipe_req),
    .pipe_req_pkt    (pipe_req_pkt),
    .pipe_gnt        (pipe_gnt),
    .pipe_valid_mm5  (pipe_valid_mm5),
    .pipe_pkt_mm5    (pipe_pkt_mm5),
    .pipe_action_mm5 (pipe_action_mm5),
    .stq_valids      (stq_valids)
);

mem_pipe u_mem_pipe (
    .clk             (clk),
    .arst_n          (arst_n),
    .nuke            (nuke),
    .oldest_robid    (oldest_robid),
    .pipe_stall      (pipe_stall),
    .pipe_req        (pipe_req),
    .pipe_req_pkt    (pipe_req_pkt),
    .pipe_gnt        (pipe_gnt),
    .pipe_valid_mm5  (pipe_valid_mm5),
    .pipe_pkt_mm5    (pipe_pkt_mm5),
    .pipe_action_mm5 (pipe_action_mm5),
    .commit_valid    (commit_valid),
    .commit_pkt      (commit_pkt)
);

endmodule

//--- dv/stq_vectors.svh
`ifndef STQ_VECTORS_SVH
`define STQ_VECTORS_SVH

`include "stq_cfg.svh"

localparam mem_pkg::t_opcode st = mem_pkg::OP_STORE;
localparam mem_pkg::t_opcode ld = mem_pkg::OP_LOAD;
localparam mem_pkg::t_opcode al = mem_pkg::OP_ALU;

typedef struct packed {
    logic iss;
    logic nuke;
    logic stall;
    logic expect_commit;  // Push exp_rob / exp_addr onto the commit queue
    logic drain;          // Wait until every queued commit has arrived
} t_row_flags;

typedef struct packed {
    t_row_flags                  f;
    mem_pkg::t_opcode            op;
    mem_pkg::t_rob_id            rob;
    mem_pkg::t_stq_id            stq;
    logic [`MEM_ADDR_W-1:0]      addr;
    mem_pkg::t_rob_id            nuke_rob;
    mem_pkg::t_rob_id            oldest;
    logic [7:0]                  hold;      // Idle cycles after the row
    mem_pkg::t_rob_id            exp_rob;
    logic [`MEM_ADDR_W-1:0]      exp_addr;
    logic [`STQ_NUM_ENTRIES-1:0] occ;       // stq_valids after hold or drain
} t_vec_row;

localparam int num_rows = 23;

// flags {iss nuke stall expect drain}, op, rob, stq, addr, nuke rob, oldest, hold,
// expected rob, expected addr, occupancy
localparam t_vec_row vectors [num_rows] = '{
    '{5'b10011, st, 5'd1,  3'd0, 16'h0100, 5'd0,  5'd0,  8'd0,  5'd1,  16'h0100, 8'h00},
    '{5'b10000, al, 5'd2,  3'd1, 16'h0200, 5'd0,  5'd0,  8'd3,  5'd0,  16'h0000, 8'h00},
    '{5'b10000, ld, 5'd3,  3'd2, 16'h0300, 5'd0,  5'd0,  8'd3,  5'd0,  16'h0000, 8'h00},
    // Distinct lines back to back
    '{5'b10010, st, 5'd4,  3'd0, 16'h1000, 5'd0,  5'd0,  8'd0,  5'd4,  16'h1000, 8'h00},
    '{5'b10010, st, 5'd5,  3'd1, 16'h1010, 5'd0,  5'd0,  8'd0,  5'd5,  16'h1010, 8'h00},
    '{5'b10010, st, 5'd6,  3'd2, 16'h1020, 5'd0,  5'd0,  8'd0,  5'd6,  16'h1020, 8'h00},
    '{5'b10011, st, 5'd7,  3'd3, 16'h1030, 5'd0,  5'd0,  8'd0,  5'd7,  16'h1030, 8'h00},
    // Same line, second one replays
    '{5'b10010, st, 5'd8,  3'd4, 16'h2000, 5'd0,  5'd0,  8'd0,  5'd8,  16'h2000, 8'h00},
    '{5'b10011, st, 5'd9,  3'd5, 16'h2008, 5'd0,  5'd0,  8'd0,  5'd9,  16'h2008, 8'h00},
    // Stalled pipe, issued in falling stqid order
    '{5'b10100, st, 5'd10, 3'd6, 16'h3000, 5'd0,  5'd0,  8'd0,  5'd0,  16'h0000, 8'h00},
    '{5'b10100, st, 5'd11, 3'd5, 16'h3100, 5'd0,  5'd0,  8'd0,  5'd0,  16'h0000, 8'h00},
    '{5'b10100, st, 5'd12, 3'd4, 16'h3200, 5'd0,  5'd0,  8'd8,  5'd0,  16'h0000, 8'h70},
    '{5'b00100, al, 5'd0,  3'd0, 16'h0000, 5'd0,  5'd0,  8'd10, 5'd0,  16'h0000, 8'h70},
    '{5'b00010, al, 5'd0,  3'd0, 16'h0000, 5'd0,  5'd0,  8'd0,  5'd12, 16'h3200, 8'h00},
    '{5'b00010, al, 5'd0,  3'd0, 16'h0000, 5'd0,  5'd0,  8'd0,  5'd11, 16'h3100, 8'h00},
    '{5'b00011, al, 5'd0,  3'd0, 16'h0000, 5'd0,  5'd0,  8'd0,  5'd10, 16'h3000, 8'h00},
    // Wrapped ROB ids, nuke at 30 with oldest 28
    '{5'b10010, st, 5'd28, 3'd0, 16'h4000, 5'd0,  5'd28, 8'd0,  5'd28, 16'h4000, 8'h00},
    '{5'b10010, st, 5'd29, 3'd1, 16'h4010, 5'd0,  5'd28, 8'd0,  5'd29, 16'h4010, 8'h00},
    '{5'b10000, st, 5'd30, 3'd2, 16'h4020, 5'd0,  5'd28, 8'd0,  5'd0,  16'h0000, 8'h00},
    '{5'b10000, st, 5'd31, 3'd3, 16'h4030, 5'd0,  5'd28, 8'd0,  5'd0,  16'h0000, 8'h00},
    '{5'b10000, st, 5'd0,  3'd4, 16'h4040, 5'd0,  5'd28, 8'd0,  5'd0,  16'h0000, 8'h00},
    '{5'b01001, al, 5'd0,  3'd0, 16'h0000, 5'd30, 5'd28, 8'd0,  5'd0,  16'h0000, 8'h00},
    '{5'b00000, al, 5'd0,  3'd0, 16'h0000, 5'd0,  5'd28, 8'd12, 5'd0,  16'h0000, 8'h00}
};

`endif

//--- dv/mem_subsys_tb.sv
`timescale 1ns/1ns
`include "stq_cfg.svh"

module mem_subsys_tb;

`include "stq_vectors.svh"

localparam int timeout_cycles = 40 * num_rows + 100;

logic                        clk;
logic                        arst_n;
logic                        iss_valid;
mem_pkg::t_iss_pkt           iss_pkt;
mem_pkg::t_nuke_pkt          nuke;
mem_pkg::t_rob_id            oldest_robid;
logic                        pipe_stall;
logic                        commit_valid;
mem_pkg::t_commit_pkt        commit_pkt;
logic [`STQ_NUM_ENTRIES-1:0] stq_valids;

logic [`MEM_DATA_W-1:0]      data_of_rob [1 << `ROB_ID_W];  // Random store data per robid
mem_pkg::t_commit_pkt        exp_q [$];
mem_pkg::t_commit_pkt        mon_exp;
int                          cycle_cnt = 0;

mem_subsys UUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .iss_valid    (iss_valid),
    .iss_pkt      (iss_pkt),
    .nuke         (nuke),
    .oldest_robid (oldest_robid),
    .pipe_stall   (pipe_stall),
    .commit_valid (commit_valid),
    .commit_pkt   (commit_pkt),
    .stq_valids   (stq_valids)
);

always #5 clk = ~clk;

// ------------------------------------------------------------
// Checks
// ------------------------------------------------------------

task automatic report_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
endtask

task automatic check_commit(input mem_pkg::t_commit_pkt exp_pkt,
                            input mem_pkg::t_commit_pkt act_pkt);
    if (act_pkt !== exp_pkt) begin
        report_error($sformatf("mismatch commit_pkt expected %h actual %h", exp_pkt, act_pkt));
    end
endtask

task automatic check_occupancy(input logic [`STQ_NUM_ENTRIES-1:0] exp_valids,
                               input logic [`STQ_NUM_ENTRIES-1:0] act_valids);
    if (act_valids !== exp_valids) begin
        report_error($sformatf("mismatch stq_valids expected %h actual %h",
                               exp_valids, act_valids));
    end
endtask

task automatic drive_row(input t_vec_row row);
    iss_valid      = row.f.iss;
    iss_pkt.opcode = row.op;
    iss_pkt.robid  = row.rob;
    iss_pkt.stqid  = row.stq;
    iss_pkt.vaddr  = row.addr;
    iss_pkt.data   = data_of_rob[row.rob];
    nuke.valid     = row.f.nuke;
    nuke.robid     = row.nuke_rob;
    oldest_robid   = row.oldest;
    pipe_stall     = row.f.stall;
endtask

// Commits sampled mid-cycle and matched in order against the queue
always @(negedge clk) begin
    if (arst_n && commit_valid) begin
        if (exp_q.size() == 0) begin
            report_error($sformatf("unexpected commit for robid %h", commit_pkt.robid));
        end else begin
            mon_exp = exp_q.pop_front();
            check_commit(mon_exp, commit_pkt);
        end
    end
end

always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > timeout_cycles) begin
        report_error($sformatf("timeout after %0d cycles with %0d commits outstanding",
                               cycle_cnt, exp_q.size()));
    end
end

// ------------------------------------------------------------
// Stimulus
// ------------------------------------------------------------

initial begin
    t_vec_row             row;
    mem_pkg::t_commit_pkt exp_pkt;
    clk          = 1'b0;
    arst_n       = 1'b0;
    iss_valid    = 1'b0;
    iss_pkt      = '0;
    nuke         = '0;
    oldest_robid = '0;
    pipe_stall   = 1'b0;
    void'($urandom(32'he5b2));
    for (int i = 0; i < (1 << `ROB_ID_W); i++) begin
        data_of_rob[i] = $urandom;
    end

    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_occupancy('0, stq_valids);

    for (int r = 0; r < num_rows; r++) begin
        row = vectors[r];
        if (row.f.expect_commit) begin
            exp_pkt.robid = row.exp_rob;
            exp_pkt.vaddr = row.exp_addr;
            exp_pkt.data  = data_of_rob[row.exp_rob];
            exp_q.push_back(exp_pkt);
        end
        drive_row(row);
        @(posedge clk);
        #1;
        iss_valid  = 1'b0;  // Issue and nuke last one cycle
        nuke.valid = 1'b0;
        repeat (row.hold) begin
            @(posedge clk);
            #1;
        end
        while (row.f.drain && exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        if (row.f.drain || row.hold != 0) begin
            check_occupancy(row.occ, stq_valids);
        end
    end

    if (exp_q.size() != 0) begin
        report_error("run ended with expected commits still outstanding");
    end else begin
        $display("** PASS **");
        $finish;
    end
end

endmodule

//--- project.f
+incdir+verilog
+incdir+dv
verilog/mem_pkg.sv
verilog/find_first_arb.sv
verilog/stq_entry.sv
verilog/storeq.sv
verilog/mem_pipe.sv
verilog/mem_subsys.sv
dv/mem_subsys_tb.sv
